/* include/shared_alu_macros.svh */
////////////////////////////////////////////////////////////
// width and iteration-count macros for the shared ALU
////////////////////////////////////////////////////////////
`ifndef SHARED_ALU_MACROS_SVH
`define SHARED_ALU_MACROS_SVH

// operand / result word
`define SA_OPERAND_W 13

// multiplier fraction, also the annealing quotient length
`define SA_FRAC_W 8

// full quotient for T27 / T36
`define SA_QUOT_W 9

`define SA_CNT_W 4              // iteration counters, covers up to 9

// dividend left shifts for the two cooling-factor divisions
`define SA_DIV_SHIFT_T27 7
`define SA_DIV_SHIFT_T36 6

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the shared ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f shared_alu.f \
    --top-module shared_alu_tb \
    -Mdir "$BUILD_DIR" -o shared_alu_sim

# keep running past assertion errors so the testbench can report
"./$BUILD_DIR/shared_alu_sim" +verilator+error+limit+10000 | tee "$LOG"

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* shared_alu.f */
+incdir+include
source/alu_data_pkg.sv
source/alu_ctrl_pkg.sv
source/shift_add_multiplier.sv
source/restoring_divider.sv
source/alu_sequencer.sv
source/shared_alu_top.sv
verification/shared_alu_props.sv
verification/shared_alu_tb.sv

/* source/alu_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// control types: opcode, request/response words, FSM states
////////////////////////////////////////////////////////////
package alu_ctrl_pkg;

    // data words the structs are built on, passed on to users
    import alu_data_pkg::operand_t;
    import alu_data_pkg::quot_t;
    import alu_data_pkg::mul_mode_e;
    import alu_data_pkg::div_mode_e;
    export alu_data_pkg::operand_t;
    export alu_data_pkg::quot_t;
    export alu_data_pkg::mul_mode_e;
    export alu_data_pkg::div_mode_e;

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } alu_op_e;

    typedef struct packed {
        alu_op_e    op;     // which unit
        logic [1:0] mode;   // raw mode, meaning depends on op
        operand_t   x;      // multiplicand / dividend
        operand_t   y;      // fraction / divisor
    } alu_req_t;            // 29b

    typedef struct packed {
        alu_op_e    op;     // echo of the request op
        operand_t   result;
    } alu_rsp_t;            // 14b

    typedef enum logic [1:0] {IDLE, BUSY, HOLD} seq_state_e;
    typedef enum logic [1:0] {M_IDLE, M_ADD, M_SHIFT} mul_state_e;
    typedef enum logic [1:0] {D_IDLE, D_SHIFT, D_TRIAL} div_state_e;

endpackage

/* source/alu_data_pkg.sv */
////////////////////////////////////////////////////////////
// arithmetic data types: operand, fraction, quotient words
// and the multiply / divide mode encodings
////////////////////////////////////////////////////////////
`include "shared_alu_macros.svh"

package alu_data_pkg;

    typedef logic [`SA_OPERAND_W-1:0] operand_t;    // 13b operand or result
    typedef logic [`SA_FRAC_W-1:0]    frac_t;       // unsigned .8 fraction
    typedef logic [`SA_QUOT_W-1:0]    quot_t;       // 9b quotient

    // multiply modes, value 3 is folded onto MUL_BOUND upstream
    typedef enum logic [1:0] {
        MUL_PURE  = 2'd0,   // x * frac
        MUL_FRAC  = 2'd1,   // x * (1 + frac)
        MUL_BOUND = 2'd2    // x * 2
    } mul_mode_e;

    // divide modes, value 3 is folded onto DIV_ANNEAL upstream
    typedef enum logic [1:0] {
        DIV_ANNEAL = 2'd0,  // x*256/y, x < y expected
        DIV_T27    = 2'd1,  // x*128/y
        DIV_T36    = 2'd2   // x*64/y
    } div_mode_e;

endpackage

/* source/alu_sequencer.sv */
////////////////////////////////////////////////////////////
// request accept, unit dispatch, held response
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "shared_alu_macros.svh"

module alu_sequencer (
    input  logic                    CLK,
    input  logic                    RST_N,
    input  alu_ctrl_pkg::alu_req_t  req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output alu_ctrl_pkg::alu_rsp_t  rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic                    mul_start,
    output alu_data_pkg::mul_mode_e mul_mode,
    output logic                    div_start,
    output alu_data_pkg::div_mode_e div_mode,
    output alu_data_pkg::operand_t  x,
    output alu_data_pkg::operand_t  y,
    input  logic                    mul_done,
    input  alu_data_pkg::operand_t  mul_result,
    input  logic                    div_done,
    input  alu_data_pkg::quot_t     div_result
);
    import alu_data_pkg::*;
    import alu_ctrl_pkg::*;

    seq_state_e state_q;
    alu_req_t   req_q;          // accepted request, held for the unit
    alu_rsp_t   rsp_q;
    logic       accept;
    logic       unit_done;      // done of the unit that op picked

    assign req_ready = (state_q == IDLE);
    assign accept    = req_valid & req_ready;
    assign rsp_valid = (state_q == HOLD);
    assign rsp       = rsp_q;
    assign x         = req_q.x;
    assign y         = req_q.y;
    assign unit_done = (req_q.op == OP_MUL) ? mul_done : div_done;

    // mode 3 goes to each unit's default mode
    assign mul_mode = (req_q.mode == 2'd3) ? MUL_BOUND : mul_mode_e'(req_q.mode);
    assign div_mode = (req_q.mode == 2'd3) ? DIV_ANNEAL : div_mode_e'(req_q.mode);

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state_q   <= IDLE;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= accept && (req.op == OP_MUL);  // start pulse in first BUSY cycle
            div_start <= accept && (req.op == OP_DIV);
            case (state_q)
                IDLE: if (accept)    state_q <= BUSY;
                BUSY: if (unit_done) state_q <= HOLD;
                HOLD: if (rsp_ready) state_q <= IDLE;  // response transfer
                default:             state_q <= IDLE;
            endcase
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        if (accept)
            req_q <= req;
        if (state_q == BUSY && unit_done) begin
            rsp_q.op     <= req_q.op;
            rsp_q.result <= (req_q.op == OP_MUL) ? mul_result
                                                 : operand_t'(div_result); // zero-extend
        end
    end

endmodule

/* source/restoring_divider.sv */
////////////////////////////////////////////////////////////
// serial restoring divider, annealing / T27 / T36 modes
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "shared_alu_macros.svh"

module restoring_divider (
    input  logic                    CLK,
    input  logic                    RST_N,
    input  logic                    start,
    input  alu_data_pkg::div_mode_e mode,
    input  alu_data_pkg::operand_t  x,
    input  alu_data_pkg::operand_t  y,
    output logic                    done,
    output alu_data_pkg::quot_t     quotient
);
    import alu_data_pkg::*;
    import alu_ctrl_pkg::*;

    localparam int PAIR_W = `SA_OPERAND_W + `SA_QUOT_W;

    div_state_e              state_q;
    logic [`SA_OPERAND_W:0]  rem_q;      // one spare bit for the shifted head
    quot_t                   quo_q;      // low dividend bits in, quotient bits out
    logic [`SA_CNT_W-1:0]    cnt_q;
    logic [`SA_CNT_W-1:0]    iter_q;     // 8 or 9 iterations
    logic                    last_iter;
    logic                    fits;       // trial subtract succeeds

    // decoded from the mode at start
    logic                    sat;
    quot_t                   sat_val;
    logic [`SA_CNT_W-1:0]    load_sh;
    logic [`SA_CNT_W-1:0]    load_iter;
    logic [PAIR_W-1:0]       dvd_load;

    always_comb begin
        case (mode)
            DIV_T27: begin
                sat       = (x >> 2) >= y;
                sat_val   = quot_t'(511);
                load_sh   = `SA_CNT_W'(`SA_DIV_SHIFT_T27);
                load_iter = `SA_CNT_W'(`SA_QUOT_W);
            end
            DIV_T36: begin
                sat       = (x >> 2) >= y;
                sat_val   = quot_t'(256);
                load_sh   = `SA_CNT_W'(`SA_DIV_SHIFT_T36);
                load_iter = `SA_CNT_W'(`SA_QUOT_W);
            end
            default: begin                          // annealing ratio, y = 0 lands here too
                sat       = x >= y;
                sat_val   = quot_t'(255);
                // one iteration short, so the dividend sits one place higher
                load_sh   = `SA_CNT_W'(`SA_QUOT_W);
                load_iter = `SA_CNT_W'(`SA_FRAC_W);
            end
        endcase
    end

    assign dvd_load  = {{`SA_QUOT_W{1'b0}}, x} << load_sh;
    assign fits      = rem_q >= {1'b0, y};
    assign last_iter = (cnt_q == iter_q - 1'b1);

    ////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state_q <= D_IDLE;
            cnt_q   <= '0;
            iter_q  <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                D_IDLE: begin
                    if (start) begin
                        cnt_q  <= '0;
                        iter_q <= load_iter;
                        if (sat)
                            done <= 1'b1;           // saturated, no iterations
                        else
                            state_q <= D_SHIFT;
                    end
                end
                D_SHIFT: state_q <= D_TRIAL;
                D_TRIAL: begin
                    cnt_q   <= cnt_q + 1'b1;
                    state_q <= last_iter ? D_IDLE : D_SHIFT;
                    done    <= last_iter;
                end
                default: state_q <= D_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    always_ff @(posedge CLK) begin
        case (state_q)
            D_IDLE: begin
                if (start) begin
                    rem_q    <= {1'b0, dvd_load[PAIR_W-1:`SA_QUOT_W]};
                    quo_q    <= dvd_load[`SA_QUOT_W-1:0];
                    quotient <= sat_val;            // kept only when saturated
                end
            end
            D_SHIFT: {rem_q, quo_q} <= {rem_q[`SA_OPERAND_W-1:0], quo_q, 1'b0};
            D_TRIAL: begin
                if (fits)
                    rem_q <= rem_q - {1'b0, y};     // restore = simply keep rem
                quo_q[0] <= fits;
                if (last_iter)
                    quotient <= {quo_q[`SA_QUOT_W-1:1], fits};
            end
            default: ;
        endcase
    end

endmodule

/* source/shared_alu_top.sv */
////////////////////////////////////////////////////////////
// shared ALU top: sequencer plus multiply / divide units
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module shared_alu_top (
    input  logic                   CLK,
    input  logic                   RST_N,
    input  alu_ctrl_pkg::alu_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output alu_ctrl_pkg::alu_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready
);
    import alu_ctrl_pkg::*;

    // sequencer to units
    logic      mul_start, div_start;
    logic      mul_done, div_done;
    mul_mode_e mul_mode;
    div_mode_e div_mode;
    operand_t  x, y;            // held operands, shared by both units
    operand_t  mul_result;
    quot_t     div_result;

    alu_sequencer u_seq (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .mul_start  (mul_start),
        .mul_mode   (mul_mode),
        .div_start  (div_start),
        .div_mode   (div_mode),
        .x          (x),
        .y          (y),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .div_done   (div_done),
        .div_result (div_result)
    );

    shift_add_multiplier u_mul (
        .CLK    (CLK),
        .RST_N  (RST_N),
        .start  (mul_start),
        .mode   (mul_mode),
        .x      (x),
        .y      (y),
        .done   (mul_done),
        .result (mul_result)
    );

    restoring_divider u_div (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .start    (div_start),
        .mode     (div_mode),
        .x        (x),
        .y        (y),
        .done     (div_done),
        .quotient (div_result)
    );

endmodule

/* source/shift_add_multiplier.sv */
////////////////////////////////////////////////////////////
// serial shift-and-add fractional multiplier
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "shared_alu_macros.svh"

module shift_add_multiplier (
    input  logic                   CLK,
    input  logic                   RST_N,
    input  logic                   start,
    input  alu_data_pkg::mul_mode_e mode,
    input  alu_data_pkg::operand_t x,
    input  alu_data_pkg::operand_t y,
    output logic                   done,
    output alu_data_pkg::operand_t result
);
    import alu_data_pkg::*;
    import alu_ctrl_pkg::*;

    localparam int ACC_W = `SA_OPERAND_W + `SA_FRAC_W + 1;  // 13+8 plus add carry

    mul_state_e            state_q;
    mul_mode_e             mode_q;      // latched at start
    logic [ACC_W-1:0]      acc_q;
    logic [ACC_W-1:0]      acc_shr;
    frac_t                 frac_q;      // remaining multiplier bits, LSB first
    logic [`SA_CNT_W-1:0]  cnt_q;
    logic                  last_bit;
    operand_t              prod_frac;   // floor(x*y/256) once all bits are in
    operand_t              fin;

    assign acc_shr   = acc_q >> 1;
    assign last_bit  = (cnt_q == `SA_CNT_W'(`SA_FRAC_W - 1));
    assign prod_frac = acc_shr[`SA_OPERAND_W+`SA_FRAC_W-1:`SA_FRAC_W];
    assign fin       = (mode_q == MUL_FRAC) ? prod_frac + x : prod_frac;  // mixed adds x once more

    ////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state_q <= M_IDLE;
            cnt_q   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;                   // single-cycle pulse
            case (state_q)
                M_IDLE: begin
                    if (start) begin
                        cnt_q <= '0;
                        if (mode == MUL_PURE || mode == MUL_FRAC)
                            state_q <= M_ADD;
                        else
                            done <= 1'b1;   // bounded answers at once
                    end
                end
                M_ADD: begin
                    if (frac_q[0]) begin
                        state_q <= M_SHIFT; // add this cycle, shift next
                    end else begin
                        cnt_q <= cnt_q + 1'b1;  // zero bit, shift only
                        if (last_bit) begin
                            state_q <= M_IDLE;
                            done    <= 1'b1;
                        end
                    end
                end
                M_SHIFT: begin
                    cnt_q   <= cnt_q + 1'b1;
                    state_q <= last_bit ? M_IDLE : M_ADD;
                    done    <= last_bit;
                end
                default: state_q <= M_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    always_ff @(posedge CLK) begin
        case (state_q)
            M_IDLE: begin
                if (start) begin
                    acc_q  <= '0;
                    frac_q <= y[`SA_FRAC_W-1:0];    // only the low 8 bits count
                    mode_q <= mode;
                    result <= x << 1;               // bounded result, truncated
                end
            end
            M_ADD: begin
                if (frac_q[0]) begin
                    acc_q <= acc_q + {1'b0, x, {`SA_FRAC_W{1'b0}}};  // x at the top
                end else begin
                    acc_q  <= acc_shr;
                    frac_q <= frac_q >> 1;
                    if (last_bit)
                        result <= fin;
                end
            end
            M_SHIFT: begin
                acc_q  <= acc_shr;
                frac_q <= frac_q >> 1;
                if (last_bit)
                    result <= fin;
            end
            default: ;
        endcase
    end

endmodule

/* verification/shared_alu_props.sv */
////////////////////////////////////////////////////////////
// handshake and result assertions, bound into the ALU top
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module shared_alu_props (
    input logic                   CLK,
    input logic                   RST_N,
    input logic                   req_ready,
    input alu_ctrl_pkg::alu_rsp_t rsp,
    input logic                   rsp_valid,
    input logic                   rsp_ready
);
    import alu_ctrl_pkg::*;

    alu_rsp_t    exp_rsp         = '0;  // reference response, set by the testbench
    int unsigned result_fail_cnt = 0;
    int unsigned proto_fail_cnt  = 0;

    // result and echoed op at every response transfer
    a_result: assert property (@(posedge CLK) disable iff (!RST_N)
        (rsp_valid && rsp_ready) |-> (rsp == exp_rsp))
        else begin
            $error("response differs from the reference value");
            result_fail_cnt++;
        end

    // held response must not move under back-pressure
    a_stable: assert property (@(posedge CLK) disable iff (!RST_N)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else begin
            $error("response changed or dropped while rsp_ready was low");
            proto_fail_cnt++;
        end

    a_no_accept: assert property (@(posedge CLK) disable iff (!RST_N)
        rsp_valid |-> !req_ready)   // one item in flight
        else begin
            $error("req_ready high while a response is pending");
            proto_fail_cnt++;
        end

    // first cycle out of reset
    a_reset: assert property (@(posedge CLK)
        $rose(RST_N) |-> (!rsp_valid && req_ready))
        else begin
            $error("wrong handshake state after reset");
            proto_fail_cnt++;
        end

endmodule

bind shared_alu_top shared_alu_props u_props (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

/* verification/shared_alu_tb.sv */
////////////////////////////////////////////////////////////
// shared ALU testbench: clock, reset, stimulus, reference
// model, watchdog and report
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module shared_alu_tb;
    import alu_data_pkg::*;
    import alu_ctrl_pkg::*;

    localparam int N_RAND    = 40;                  // random requests per mode
    localparam int N_REQ     = 320;                 // upper bound on requests in the run
    localparam int WD_CYCLES = N_REQ * 25 + 1000;   // 25 cycles a request plus margin

    logic        CLK;
    logic        RST_N;
    alu_req_t    req;
    logic        req_valid;
    logic        req_ready;
    alu_rsp_t    rsp;
    logic        rsp_valid;
    logic        rsp_ready;

    logic [31:0] lcg_state = 32'hd316;
    string       test_name;
    int          test_reqs;
    int          fails_at_start;
    int          tests_run;
    int          tests_failed;

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;     // 20 ns period
    end

    shared_alu_top u_dut (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    ////////////////////////////////////////////////////////////
    // random numbers and reference model
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic operand_t rand_operand(int unsigned limit);   // 0 .. limit-1
        logic [31:0] r;
        r = next_rand();
        return operand_t'((r >> 8) % limit);  // low LCG bits are weak
    endfunction

    function automatic alu_req_t make_req(alu_op_e op, logic [1:0] mode, operand_t x,
                                          operand_t y);
        alu_req_t r;
        r.op   = op;
        r.mode = mode;
        r.x    = x;
        r.y    = y;
        return r;
    endfunction

    function automatic alu_req_t mul_req(logic [1:0] mode);
        return make_req(OP_MUL, mode, rand_operand(8192), rand_operand(8192));
    endfunction

    // divisor never zero, dividend kept below the saturation point
    function automatic alu_req_t div_req(logic [1:0] mode);
        operand_t    y;
        int unsigned span;
        y    = rand_operand(8191) + 13'd1;
        span = (mode == 2'd1 || mode == 2'd2) ? 32'(y) * 4 : 32'(y);
        if (span > 8192)
            span = 8192;
        return make_req(OP_DIV, mode, rand_operand(span), y);
    endfunction

    function automatic alu_rsp_t expected_rsp(alu_req_t r);
        int unsigned xv;
        int unsigned yv;
        int unsigned q;
        alu_rsp_t    e;
        xv = 32'(r.x);
        yv = 32'(r.y);
        if (r.op == OP_MUL) begin
            case (r.mode)
                2'd0:    q = (xv * (yv % 256)) / 256;           // pure fraction
                2'd1:    q = xv + (xv * (yv % 256)) / 256;      // mixed fraction
                default: q = 2 * xv;                            // bounded, mode 3 too
            endcase
        end else begin
            case (r.mode)
                2'd1:    q = (xv / 4 >= yv) ? 511 : (xv * 128) / yv;
                2'd2:    q = (xv / 4 >= yv) ? 256 : (xv * 64) / yv;
                default: q = (xv >= yv) ? 255 : (xv * 256) / yv;  // y = 0 saturates
            endcase
        end
        e.op     = r.op;
        e.result = operand_t'(q);   // truncated to 13b
        return e;
    endfunction

    function automatic int total_fails();
        return u_dut.u_props.result_fail_cnt + u_dut.u_props.proto_fail_cnt;
    endfunction

    ////////////////////////////////////////////////////////////
    // drivers
    task automatic apply_reset();
        RST_N = 1'b0;
        repeat (2) @(posedge CLK);
        #2 RST_N = 1'b1;
    endtask

    // one request through the DUT; with queue_next the following request waits
    // on the request channel while this one is busy and held
    task automatic transact(input alu_req_t r, input bit queue_next, input alu_req_t nxt,
                            input int unsigned hold);
        alu_rsp_t    exp;
        alu_rsp_t    seen;
        int unsigned fails_before;
        exp                   = expected_rsp(r);
        u_dut.u_props.exp_rsp = exp;
        req                   = r;
        req_valid             = 1'b1;
        while (!req_ready) begin
            @(posedge CLK);
            #2;
        end
        @(posedge CLK);                 // accepted on this edge
        #2;
        if (queue_next)
            req = nxt;
        else
            req_valid = 1'b0;
        while (!rsp_valid) begin
            @(posedge CLK);
            #2;
        end
        repeat (hold) begin             // back-pressure
            @(posedge CLK);
            #2;
        end
        seen         = rsp;
        fails_before = u_dut.u_props.result_fail_cnt;
        rsp_ready    = 1'b1;
        @(posedge CLK);                 // response transfer
        #2;
        rsp_ready = 1'b0;
        test_reqs++;
        if (u_dut.u_props.result_fail_cnt != fails_before)
            $display("ERROR %s: expected op=%0d result=%0d, actual op=%0d result=%0d",
                     test_name, exp.op, exp.result, seen.op, seen.result);
    endtask

    task automatic send_one(input alu_req_t r);
        transact(r, 1'b0, r, 0);
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_reqs      = 0;
        fails_at_start = total_fails();
    endtask

    task automatic end_test();
        int n;
        n = total_fails() - fails_at_start;
        tests_run++;
        if (n > 0)
            tests_failed++;
        $display("%s: %0d requests, %0d failed checks", test_name, test_reqs, n);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    task automatic test_multiply();
        start_test("multiply");
        for (int m = 0; m < 4; m++)     // mode 3 acts as bounded
            for (int i = 0; i < N_RAND; i++)
                send_one(mul_req(2'(m)));
        end_test();
    endtask

    task automatic test_anneal();
        start_test("anneal_div");
        for (int i = 0; i < N_RAND; i++)
            send_one(div_req((i % 5 == 4) ? 2'd3 : 2'd0));
        send_one(make_req(OP_DIV, 2'd0, 13'd5000, 13'd1234));  // x > y
        send_one(make_req(OP_DIV, 2'd0, 13'd777, 13'd777));    // x == y
        send_one(make_req(OP_DIV, 2'd0, 13'd0, 13'd0));        // y = 0
        send_one(make_req(OP_DIV, 2'd0, 13'd4000, 13'd0));
        send_one(make_req(OP_DIV, 2'd3, 13'd100, 13'd50));
        end_test();
    endtask

    task automatic test_scaled_div();
        start_test("t27_t36_div");
        for (int i = 0; i < N_RAND / 2; i++)
            send_one(div_req(2'd1));
        for (int i = 0; i < N_RAND / 2; i++)
            send_one(div_req(2'd2));
        send_one(make_req(OP_DIV, 2'd1, 13'd400, 13'd100));    // x/4 == y, saturates
        send_one(make_req(OP_DIV, 2'd1, 13'd399, 13'd100));    // just below
        send_one(make_req(OP_DIV, 2'd1, 13'd8191, 13'd0));
        send_one(make_req(OP_DIV, 2'd2, 13'd1000, 13'd3));
        send_one(make_req(OP_DIV, 2'd2, 13'd403, 13'd100));
        end_test();
    endtask

    task automatic test_backpressure();
        alu_req_t cur;
        alu_req_t nxt;
        start_test("backpressure");
        cur = mul_req(2'd0);
        for (int i = 0; i < 30; i++) begin
            nxt = (next_rand() % 2 == 0) ? mul_req(2'(next_rand() % 4))
                                         : div_req(2'(next_rand() % 4));
            transact(cur, i < 29, nxt, next_rand() % 6);
            cur = nxt;
        end
        end_test();
    endtask

    // fresh reset, then multiply and divide alternate back to back
    task automatic test_reset_interleave();
        alu_req_t cur;
        alu_req_t nxt;
        start_test("reset_interleave");
        apply_reset();
        cur = mul_req(2'(next_rand() % 4));
        for (int i = 0; i < 30; i++) begin
            nxt = (i % 2 == 1) ? mul_req(2'(next_rand() % 4)) : div_req(2'(next_rand() % 4));
            transact(cur, i < 29, nxt, 0);
            cur = nxt;
        end
        end_test();
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    initial begin
        req          = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        RST_N        = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        apply_reset();
        test_multiply();
        test_anneal();
        test_scaled_div();
        test_backpressure();
        test_reset_interleave();
        repeat (2) @(posedge CLK);
        $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed,
                 total_fails());
        if (total_fails() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge CLK);
        $display("timeout: the DUT did not finish all requests within %0d cycles", WD_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
